//--- Makefile
# Verilator build and run of the MIDI synthesizer testbench

VERILATOR ?= verilator
TOP ?= midiSynthTb
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_MSG ?= RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Overridable: VERILATOR TOP FLIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- design/midiChannel.sv
// --------------------
// One voice of the allocation chain
// Claim and release, note-on forwarding
// Increment and amplitude lookup
// --------------------

module midiChannel import midiPkg::*, synthPkg::*;
(
	input  logic iCLK,
	input  logic iRST,
	input  logic [noteWidth-1:0] iNoteNumber,
	input  logic [velWidth-1:0] iVelocity,
	input  logic iNoteOn,
	input  logic iNoteOff,
	output logic oNoteOnPipe,	// Note-on handed to next channel
	output logic [incWidth-1:0] oPhaseInc,
	output logic [ampWidth-1:0] oAmp,
	output logic oPlay
);

	logic [1:0] run;	// Bit 0 busy flag, bit 1 delayed copy drives play
	logic [noteWidth-1:0] noteReg;
	logic [velWidth-1:0] velReg;
	logic claim;
	logic noteRelease;
	logic [3:0] semitone;
	logic [3:0] octaveShift;

	// --------------------
	// Allocation
	// --------------------
	assign claim = !run[0] && iNoteOn && !iNoteOff;
	assign noteRelease = run[0] && !iNoteOn && iNoteOff && (noteReg == iNoteNumber);

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			run <= 2'b00;
			oNoteOnPipe <= 1'b0;
		end
		else
		begin
			run[1] <= run[0];
			if (claim || noteRelease)
				run[0] <= !run[0];	// Toggle on claim or matching release
			oNoteOnPipe <= run[0] && iNoteOn;	// Busy, pass it down the chain
		end
	end

	// Note captured only while free
	always_ff @(posedge iCLK)
	begin
		if (!run[0] && iNoteOn)
		begin
			noteReg <= iNoteNumber;
			velReg <= iVelocity;
		end
	end

	// --------------------
	// Pitch and level
	// --------------------
	always_comb
	begin
		semitone = 4'(noteReg % 7'd12);
		octaveShift = 4'(4'd10 - 4'(noteReg / 7'd12));	// Octaves below the top
	end

	always_ff @(posedge iCLK)
	begin
		oPhaseInc <= octaveInc[semitone] >> octaveShift;
		oAmp <= run[0] ? ampWidth'({velReg, 8'd0}) : '0;	// Silent when stopped
	end

	assign oPlay = run[1];

	// Byte spacing keeps a travelling note-on clear of the next note-off
	assert property (@(posedge iCLK) disable iff (iRST) !(iNoteOn && iNoteOff));

endmodule

//--- design/midiParser.sv
// --------------------
// MIDI byte stream parser
// Running status, note-on and note-off pulses
// --------------------

module midiParser import midiPkg::*;
(
	input  logic iCLK,
	input  logic iRST,
	input  logic [7:0] iByte,
	input  logic iByteStrobe,
	output logic [noteWidth-1:0] noteNumber,	// Held until next message completes
	output logic [velWidth-1:0] velocity,
	output logic noteOnPulse,
	output logic noteOffPulse
);

	parserState state;
	midiOpcode opcode;				// Latched from last status byte
	midiOpcode statusOp;			// Decode of incoming byte
	logic [noteWidth-1:0] dataNote;	// First data byte, waits for velocity
	logic isStatus;
	logic isOn;

	assign isStatus = iByte[7];

	// --------------------
	// Status decode
	// --------------------
	always_comb
	begin
		case (iByte[7:4])
			4'h8: statusOp = opNoteOff;
			4'h9: statusOp = opNoteOn;
			default: statusOp = opOther;
		endcase
	end

	// Velocity zero on a note-on is a release
	assign isOn = (opcode == opNoteOn) && (iByte[6:0] != '0);

	// --------------------
	// Message FSM
	// --------------------
	always_ff @(posedge iCLK)
	begin
		noteOnPulse <= 1'b0;	// Pulses last one cycle
		noteOffPulse <= 1'b0;
		if (iRST)
		begin
			state <= stIdle;
			opcode <= opOther;
		end
		else if (iByteStrobe)
		begin
			if (isStatus)
			begin
				opcode <= statusOp;
				state <= stData1;
			end
			else
			begin
				case (state)
					stData1:
					begin
						state <= stData2;
					end
					stData2:
					begin
						state <= stData1;	// Running status
						noteOnPulse <= isOn;
						noteOffPulse <= (opcode == opNoteOff) || ((opcode == opNoteOn) && !isOn);
					end
					default: state <= stIdle;	// Stray data before any status
				endcase
			end
		end
	end

	// Payload capture, no reset needed
	always_ff @(posedge iCLK)
	begin
		if (iByteStrobe && !isStatus && state == stData1)
			dataNote <= iByte[noteWidth-1:0];
		if (iByteStrobe && !isStatus && state == stData2)
		begin
			noteNumber <= dataNote;
			velocity <= iByte[velWidth-1:0];
		end
	end

	// A completed message is either on or off, never both
	assert property (@(posedge iCLK) disable iff (iRST) !(noteOnPulse && noteOffPulse));

endmodule

//--- design/midiPkg.sv
// --------------------
// MIDI message definitions
// Note and velocity widths
// Status opcodes and parser states
// --------------------

package midiPkg;

	// --------------------
	// Field widths
	// --------------------
	localparam int noteWidth = 7;	// Note number 0..127
	localparam int velWidth = 7;	// Velocity 0..127

	// --------------------
	// Status high nibble
	// --------------------
	// Only note messages matter here
	typedef enum logic [3:0]
	{
		opNoteOff = 4'h8,
		opNoteOn = 4'h9,
		opOther = 4'hF	// Any other status, data bytes swallowed
	} midiOpcode;

	// Byte position within a message
	typedef enum logic [1:0]
	{
		stIdle,		// No status seen yet
		stData1,	// Expecting note number
		stData2		// Expecting velocity
	} parserState;

endpackage

//--- design/midiSynth.sv
// --------------------
// Polyphonic MIDI tone synthesizer top
// Parser, channel and oscillator chain, mixer
// --------------------

module midiSynth import midiPkg::*, synthPkg::*;
#(
	parameter int NumChannels = 4
)
(
	input  logic iCLK,
	input  logic iRST,
	input  logic [7:0] iByte,
	input  logic iByteStrobe,
	input  logic iSampleTick,
	output logic signed [sampleWidth-1:0] oSample,
	output logic [NumChannels-1:0] oVoiceActive,
	output logic oVoiceOverflow
);

	logic [noteWidth-1:0] noteNumber;
	logic [velWidth-1:0] velocity;
	logic noteOnPulse;
	logic noteOffPulse;
	logic [NumChannels:0] noteOnChain;	// Note-on ripples through the channels
	logic [incWidth-1:0] phaseInc [NumChannels];
	logic [ampWidth-1:0] amp [NumChannels];
	logic [NumChannels-1:0][sampleWidth-1:0] voices;

	midiParser parser
	(
		.iCLK(iCLK),
		.iRST(iRST),
		.iByte(iByte),
		.iByteStrobe(iByteStrobe),
		.noteNumber(noteNumber),
		.velocity(velocity),
		.noteOnPulse(noteOnPulse),
		.noteOffPulse(noteOffPulse)
	);

	assign noteOnChain[0] = noteOnPulse;
	assign oVoiceOverflow = noteOnChain[NumChannels];	// Fell off the end, no free voice

	// --------------------
	// Voice chain
	// --------------------
	for (genvar k = 0; k < NumChannels; k++)
	begin : voice
		midiChannel channel
		(
			.iCLK(iCLK),
			.iRST(iRST),
			.iNoteNumber(noteNumber),
			.iVelocity(velocity),
			.iNoteOn(noteOnChain[k]),
			.iNoteOff(noteOffPulse),	// Broadcast, only the matching voice reacts
			.oNoteOnPipe(noteOnChain[k+1]),
			.oPhaseInc(phaseInc[k]),
			.oAmp(amp[k]),
			.oPlay(oVoiceActive[k])
		);

		toneOscillator osc
		(
			.iCLK(iCLK),
			.iRST(iRST),
			.iSampleTick(iSampleTick),
			.iPhaseInc(phaseInc[k]),
			.iAmp(amp[k]),
			.iPlay(oVoiceActive[k]),
			.oVoice(voices[k])
		);
	end

	voiceMixer #(
		.NumChannels(NumChannels)
	) mixer
	(
		.iCLK(iCLK),
		.iRST(iRST),
		.iSampleTick(iSampleTick),
		.iVoices(voices),
		.oSample(oSample)
	);

endmodule

//--- design/synthPkg.sv
// --------------------
// Audio path definitions
// Sample, amplitude and phase widths
// Top octave phase increment table
// --------------------

package synthPkg;

	localparam int incWidth = 16;		// Phase increment
	localparam int phaseWidth = 24;		// Phase accumulator
	localparam int ampWidth = 15;		// Unsigned amplitude
	localparam int sampleWidth = 16;	// Signed audio sample

	// --------------------
	// Increments for notes 120..131
	// --------------------
	// Equal temperament steps from C, scaled to the sample tick rate
	// Lower octaves shift these right by one bit per octave
	localparam logic [incWidth-1:0] octaveInc [12] = '{
		16'd34000,	// C
		16'd36022,	// C#
		16'd38164,	// D
		16'd40433,	// D#
		16'd42837,	// E
		16'd45385,	// F
		16'd48083,	// F#
		16'd50942,	// G
		16'd53972,	// G#
		16'd57181,	// A
		16'd60581,	// A#
		16'd64184	// B
	};

endpackage

//--- design/toneOscillator.sv
// --------------------
// Square wave oscillator
// Phase accumulator, amplitude scaled output
// --------------------

module toneOscillator import synthPkg::*;
(
	input  logic iCLK,
	input  logic iRST,
	input  logic iSampleTick,
	input  logic [incWidth-1:0] iPhaseInc,
	input  logic [ampWidth-1:0] iAmp,
	input  logic iPlay,
	output logic signed [sampleWidth-1:0] oVoice
);

	logic [phaseWidth-1:0] phase;
	logic signed [sampleWidth-1:0] ampSigned;

	assign ampSigned = $signed({1'b0, iAmp});	// Amplitude is always positive

	// --------------------
	// Phase accumulator
	// --------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST || !iPlay)
			phase <= '0;	// Restart each note at phase zero
		else if (iSampleTick)
			phase <= phase + phaseWidth'(iPhaseInc);
	end

	// --------------------
	// Output sample
	// --------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST || !iPlay)
			oVoice <= '0;
		else if (iSampleTick)
		begin
			if (phase[phaseWidth-1])
				oVoice <= -ampSigned;	// Second half cycle
			else
				oVoice <= ampSigned;
		end
	end

endmodule

//--- design/voiceMixer.sv
// --------------------
// Voice mixer
// Saturating sum of all voices per sample tick
// --------------------

module voiceMixer import synthPkg::*;
#(
	parameter int NumChannels = 4
)
(
	input  logic iCLK,
	input  logic iRST,
	input  logic iSampleTick,
	input  logic [NumChannels-1:0][sampleWidth-1:0] iVoices,
	output logic signed [sampleWidth-1:0] oSample
);

	localparam int sumWidth = sampleWidth + $clog2(NumChannels) + 1;	// Room for all voices
	localparam logic signed [sumWidth-1:0] maxSum = sumWidth'((1 << (sampleWidth - 1)) - 1);
	localparam logic signed [sumWidth-1:0] minSum = -maxSum - 1;

	logic tickDelay;	// Oscillators update on the tick edge
	logic signed [sumWidth-1:0] sum;
	logic signed [sampleWidth-1:0] clamped;

	// --------------------
	// Sum and clamp
	// --------------------
	always_comb
	begin
		sum = '0;
		for (int i = 0; i < NumChannels; i++)
			sum = sum + sumWidth'($signed(iVoices[i]));	// Sign extended
		if (sum > maxSum)
			clamped = maxSum[sampleWidth-1:0];
		else if (sum < minSum)
			clamped = minSum[sampleWidth-1:0];
		else
			clamped = sum[sampleWidth-1:0];
	end

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			tickDelay <= 1'b0;
			oSample <= '0;
		end
		else
		begin
			tickDelay <= iSampleTick;
			if (tickDelay)
				oSample <= clamped;
		end
	end

	// Out of range sums land on a rail
	assert property (@(posedge iCLK) disable iff (iRST)
		tickDelay && (sum > maxSum || sum < minSum) |=>
		(oSample == maxSum[sampleWidth-1:0] || oSample == minSum[sampleWidth-1:0]));

endmodule

//--- flist.f
design/midiPkg.sv
design/synthPkg.sv
design/midiParser.sv
design/midiChannel.sv
design/toneOscillator.sv
design/voiceMixer.sv
design/midiSynth.sv
testbench/midiSynthTb.sv

//--- testbench/midiSynthStim.txt
# Commands: test name, byte hh, wait n, tick, active hh, over n (pulses since last over)
# mag n v1 .. vn accepts any of n magnitudes of oSample in hex, several commands per line
test reset_state
active 0 mag 1 0000 over 0
test single_note
byte 90 byte 3c byte 40 wait 4
active 1 tick mag 1 4000 over 0
test allocation
byte 90 byte 3e byte 40 wait 4 active 3
byte 90 byte 40 byte 40 wait 4 active 7
byte 90 byte 41 byte 40 wait 4 active f
byte 90 byte 43 byte 40 wait 4 active f over 1
test release
byte 80 byte 3e byte 00 wait 4 active d
byte 80 byte 50 byte 00 wait 4 active d
byte 90 byte 45 byte 40 wait 4 active f over 0
test running_status
byte 80 byte 3c byte 00 byte 40 byte 00 byte 41 byte 00 byte 45 byte 00 wait 4 active 0
byte 90 byte 48 byte 50 byte 4a byte 50 wait 4 active 3
byte 48 byte 00 wait 4 active 2 over 0
test saturation
byte 80 byte 4a byte 00 wait 4 active 0
byte 90 byte 3c byte 7f byte 3e byte 7f wait 4 active 3
tick mag 2 0000 7fff tick mag 2 0000 7fff
tick mag 2 0000 7fff over 0

//--- testbench/midiSynthTb.sv
// --------------------
// Testbench for the MIDI synthesizer
// Clock, reset, stim file interpreter
// Value checks, watchdog and summary
// --------------------

module midiSynthTb import synthPkg::*;;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NumChannels = 4;
	localparam int CyclesPerLine = 200;	// Watchdog budget per stim line
	localparam string StimFile = "testbench/midiSynthStim.txt";

	logic iCLK;
	logic iRST;
	logic [7:0] iByte;
	logic iByteStrobe;
	logic iSampleTick;
	logic signed [sampleWidth-1:0] oSample;
	logic [NumChannels-1:0] oVoiceActive;
	logic oVoiceOverflow;

	int lineCount = 0;
	int overTotal = 0;	// Overflow pulses so far
	int overSeen = 0;	// Total at the last over check
	int testErrors = 0;
	int totalErrors = 0;
	int testsPassed = 0;
	int testsFailed = 0;
	int magList [$];	// Accepted magnitudes of one mag command
	string testName = "";

	midiSynth #(
		.NumChannels(NumChannels)
	) uut
	(
		.iCLK(iCLK),
		.iRST(iRST),
		.iByte(iByte),
		.iByteStrobe(iByteStrobe),
		.iSampleTick(iSampleTick),
		.oSample(oSample),
		.oVoiceActive(oVoiceActive),
		.oVoiceOverflow(oVoiceOverflow)
	);

	initial
	begin
		iCLK = 1'b0;
		forever #5 iCLK = ~iCLK;	// 100 MHz
	end

	// Overflow pulses are one cycle wide
	always @(posedge iCLK)
	begin
		if (!iRST && oVoiceOverflow === 1'b1)
			overTotal <= overTotal + 1;
	end

	initial
	begin
		wait (lineCount > 0);
		repeat (lineCount * CyclesPerLine) @(posedge iCLK);
		$display("Timeout after %0d cycles, the stimulus did not finish", lineCount * CyclesPerLine);
		$display("RESULT: FAIL");
		$finish;
	end

	// --------------------
	// Stimulus and checks
	// --------------------
	task automatic countError();
		testErrors++;
		totalErrors++;
	endtask

	task automatic sendByte(input logic [7:0] value);
		int gap;
		gap = NumChannels + 3 + int'($urandom % 8);	// Note-on must clear the chain first
		@(negedge iCLK);
		iByte = value;
		iByteStrobe = 1'b1;
		@(negedge iCLK);
		iByteStrobe = 1'b0;
		repeat (gap - 1) @(negedge iCLK);
	endtask

	task automatic sampleTick();
		@(negedge iCLK);
		iSampleTick = 1'b1;
		@(negedge iCLK);
		iSampleTick = 1'b0;
		repeat (3) @(negedge iCLK);	// Oscillator then mixer register
	endtask

	task automatic checkMag();
		int mag;
		bit hit;
		string allowed;
		mag = (oSample < 0) ? -int'(oSample) : int'(oSample);
		hit = 1'b0;
		allowed = "";
		foreach (magList[i])
		begin
			allowed = {allowed, $sformatf(" 0x%0h", magList[i])};
			if (magList[i] == mag)
				hit = 1'b1;
		end
		if (!hit)
		begin
			$display("Fail |oSample|: got 0x%0h, expected one of%s", mag, allowed);
			countError();
		end
	endtask

	task automatic closeTest();
		if (testName != "")
		begin
			if (testErrors == 0)
			begin
				testsPassed++;
				$display("Test %s passed", testName);
			end
			else
			begin
				testsFailed++;
				$display("Test %s failed with %0d errors", testName, testErrors);
			end
		end
		testErrors = 0;
	endtask

	// One command per token, arguments follow it
	task automatic runStim(input int fd);
		logic [8*16-1:0] cmdBuf;
		logic [8*32-1:0] nameBuf;
		logic [8*128-1:0] lineBuf;
		string cmd;
		int arg;
		int count;
		int value;
		int code;
		while ($fscanf(fd, "%s", cmdBuf) == 1)
		begin
			cmd = string'(cmdBuf);
			case (cmd)
				"#": code = $fgets(lineBuf, fd);	// Rest of line is a comment
				"test":
				begin
					closeTest();
					code = $fscanf(fd, "%s", nameBuf);
					testName = string'(nameBuf);
				end
				"byte":
				begin
					code = $fscanf(fd, "%h", arg);
					sendByte(arg[7:0]);
				end
				"wait":
				begin
					code = $fscanf(fd, "%d", arg);
					repeat (arg) @(negedge iCLK);
				end
				"tick": sampleTick();
				"active":
				begin
					code = $fscanf(fd, "%h", arg);
					if (int'(oVoiceActive) != arg)
					begin
						$display("Fail oVoiceActive: expected 0x%0h, got 0x%0h", arg, oVoiceActive);
						countError();
					end
				end
				"mag":
				begin
					code = $fscanf(fd, "%d", count);
					magList.delete();
					repeat (count)
					begin
						code = $fscanf(fd, "%h", value);
						magList.push_back(value);
					end
					checkMag();
				end
				"over":
				begin
					code = $fscanf(fd, "%d", arg);
					if (overTotal - overSeen != arg)
					begin
						$display("Fail oVoiceOverflow pulses: expected 0x%0h, got 0x%0h",
							arg, overTotal - overSeen);
						countError();
					end
					overSeen = overTotal;
				end
				default:
				begin
					$display("Unknown stim command %s, the rest of the file is skipped", cmd);
					countError();
					return;
				end
			endcase
		end
	endtask

	// --------------------
	// Main sequence
	// --------------------
	initial
	begin
		int fd;
		int code;
		logic [8*128-1:0] lineBuf;
		void'($urandom(72604));
		iRST = 1'b1;
		iByte = '0;
		iByteStrobe = 1'b0;
		iSampleTick = 1'b0;
		fd = $fopen(StimFile, "r");
		if (fd == 0)
		begin
			$display("The stim file %s could not be opened", StimFile);
			totalErrors++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				code = $fgets(lineBuf, fd);
				if (code > 0)
					lineCount++;	// Sets the watchdog budget
			end
			$fclose(fd);
			fd = $fopen(StimFile, "r");
		end
		repeat (16) @(negedge iCLK);
		iRST = 1'b0;
		if (fd != 0)
		begin
			runStim(fd);
			$fclose(fd);
		end
		closeTest();
		$display("Summary: %0d tests passed, %0d tests failed, %0d errors",
			testsPassed, testsFailed, totalErrors);
		if (totalErrors == 0 && testsFailed == 0 && testsPassed > 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule
